// File: source/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// byte address map
`define MMIO_REG_LIMIT   32'd1024   // first address past the register region
`define MMIO_TFT_LIMIT   32'd2048   // first address past the tft region
`define MMIO_DATA_LIMIT  32'd8192   // instruction fetch starts here

// read/write/idle codes
`define MMIO_RWI_IFETCH  2'b00      // read from instruction, idle below 8192
`define MMIO_RWI_WRITE   2'b01      // write
`define MMIO_RWI_READ    2'b10      // read from data
`define MMIO_RWI_IDLE    2'b11      // idle

`define MMIO_REG_LATENCY 2          // busy cycles of a register read
`define MMIO_MEM_LATENCY 1          // busy cycles of a memory access
`define MMIO_MEM_WORDS   2048       // memory depth in words
`define MMIO_TFT_DC_BIT  2          // address bit for tft data/command select

`endif

// File: source/mmio_pkg.sv
`include "mmio_defines.svh"

package mmio_pkg;

    // address or data word
    typedef logic [31:0] word_t;

    // read/write/idle request code
    typedef logic [1:0] rwi_t;

    // word index into the data/instruction memory
    typedef logic [$clog2(`MMIO_MEM_WORDS)-1:0] mem_index_t;

    // index into the sixteen sensor registers
    typedef logic [3:0] reg_index_t;

    // tft writer fsm
    typedef enum logic [1:0] {
        tft_idle,   // waiting for a write
        tft_shift,  // frame on the wire
        tft_done    // frame sent, waiting for the request to drop
    } tft_state_t;

endpackage

// File: source/mmio_decoder.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_decoder (
    input  mmio_pkg::word_t mem_data_in,            // store data from the cpu
    input  mmio_pkg::rwi_t  rwi_in,                 // request code from the cpu
    input  mmio_pkg::word_t addr_in,                // byte address from the cpu
    input  mmio_pkg::word_t ext_data_in,            // read data from memory
    input  logic            mem_busy,               // memory still working
    input  mmio_pkg::word_t reg_data_in,            // read data from register bank
    input  logic            reg_busy,               // register bank still working
    input  logic            tft_busy,               // tft writer still shifting
    output logic            ri_out,                 // read request to register bank
    output mmio_pkg::word_t addr_out_reg,           // address to register bank
    output mmio_pkg::word_t ext_data_out,           // load data back to the cpu
    output logic            busy,                   // selected target's busy
    output mmio_pkg::word_t write_instruction_out,  // fetched instruction
    output mmio_pkg::word_t write_data_out_tft,     // word to send on spi
    output mmio_pkg::word_t addr_out_tft,           // address to tft writer
    output logic            wi_out,                 // write request to tft writer
    output mmio_pkg::rwi_t  rwi_out,                // request code to memory
    output mmio_pkg::word_t addr_out,               // address to memory
    output mmio_pkg::word_t write_data_out          // store data to memory
);

    logic in_reg;    // 0..1023
    logic in_tft;    // 1024..2047
    logic in_data;   // 2048..8191
    logic in_fetch;  // 8192 and up

    assign in_reg   = addr_in < `MMIO_REG_LIMIT;
    assign in_tft   = (addr_in >= `MMIO_REG_LIMIT) && (addr_in < `MMIO_TFT_LIMIT);
    assign in_data  = (addr_in >= `MMIO_TFT_LIMIT) && (addr_in < `MMIO_DATA_LIMIT);
    assign in_fetch = addr_in >= `MMIO_DATA_LIMIT;

    always_comb begin
        busy                  = 1'b0;            // nothing selected yet
        ri_out                = 1'b0;
        wi_out                = 1'b0;
        rwi_out               = `MMIO_RWI_IDLE;  // memory idle by default
        addr_out_reg          = '0;
        addr_out_tft          = '0;
        addr_out              = '0;
        write_data_out        = '0;
        write_data_out_tft    = '0;
        ext_data_out          = '0;
        write_instruction_out = '0;
        if (in_fetch) begin
            if (rwi_in != `MMIO_RWI_IDLE) begin              // any live code fetches here
                busy                  = mem_busy;
                rwi_out               = `MMIO_RWI_IFETCH;
                addr_out              = addr_in;          // memory folds bit 13 away
                write_instruction_out = ext_data_in;      // instruction to fetch stage
            end
        end else if (rwi_in == `MMIO_RWI_WRITE) begin
            if (in_tft) begin
                busy               = tft_busy;
                wi_out             = 1'b1;
                addr_out_tft       = addr_in;             // bit 2 picks data or command
                write_data_out_tft = mem_data_in;
            end else if (in_data) begin
                busy           = mem_busy;
                rwi_out        = `MMIO_RWI_WRITE;
                addr_out       = addr_in;
                write_data_out = mem_data_in;
            end
            // writes to the register region fall through, read only
        end else if (rwi_in == `MMIO_RWI_READ) begin
            if (in_reg) begin
                busy         = reg_busy;
                ri_out       = 1'b1;
                addr_out_reg = addr_in;
                ext_data_out = reg_data_in;               // sensor value to the cpu
            end else if (in_data) begin
                busy         = mem_busy;
                rwi_out      = `MMIO_RWI_READ;
                addr_out     = addr_in;
                ext_data_out = ext_data_in;
            end
            // tft region cannot be read
        end
    end

endmodule

// File: source/ext_register_bank.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module ext_register_bank (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ri,         // read request, held until busy drops
    input  mmio_pkg::word_t     addr,       // byte address, bits 5..2 used
    input  logic                load,       // one-cycle strobe from the sensor port
    input  mmio_pkg::reg_index_t load_addr, // register to load
    input  mmio_pkg::word_t     load_data,  // sensor value
    output mmio_pkg::word_t     data,       // read data, valid when busy drops
    output logic                busy        // high while the read is pending
);

    localparam logic [1:0] LATENCY = 2'(`MMIO_REG_LATENCY);

    mmio_pkg::word_t      regs [16];  // sensor registers
    mmio_pkg::word_t      data_q;     // registered read data
    mmio_pkg::reg_index_t rd_idx;     // upper address bits alias the lower ones
    logic [1:0]           cnt;        // cycles spent on the current read

    assign rd_idx = addr[5:2];
    assign busy   = ri && (cnt < LATENCY);
    assign data   = data_q;

    // latency counter, restarts once ri falls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!ri) begin
            cnt <= '0;
        end else if (busy) begin
            cnt <= cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;                           // bank starts cleared
            end
        end else if (load) begin
            regs[load_addr] <= load_data;                // no back-pressure on the strobe
        end
    end

    always_ff @(posedge clk) begin
        if (ri && (cnt == LATENCY - 2'd1)) begin
            data_q <= regs[rd_idx];                      // sample on the last busy cycle
        end
    end

endmodule

// File: source/tft_spi_writer.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module tft_spi_writer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wi,        // write request, held until busy drops
    input  mmio_pkg::word_t addr,      // selects data or command
    input  mmio_pkg::word_t data,      // word to shift out
    output logic            busy,      // high until the last bit is clocked
    output logic            tft_sclk,  // spi clock, toggles every cycle
    output logic            tft_mosi,  // spi data, msb first
    output logic            tft_cs_n,  // chip select, low for the frame
    output logic            tft_dc     // 1 for data, 0 for command
);

    mmio_pkg::tft_state_t state;
    mmio_pkg::word_t      shift_q;  // bits still to go, next one on top
    logic [4:0]           bit_cnt;  // bits left after the current one

    assign busy = (state == mmio_pkg::tft_shift) || ((state == mmio_pkg::tft_idle) && wi);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mmio_pkg::tft_idle;
            bit_cnt  <= '0;
            tft_sclk <= 1'b0;
            tft_mosi <= 1'b0;
            tft_cs_n <= 1'b1;  // deselected
            tft_dc   <= 1'b0;
        end else begin
            case (state)
                mmio_pkg::tft_idle: begin
                    if (wi) begin
                        state    <= mmio_pkg::tft_shift;
                        tft_cs_n <= 1'b0;
                        tft_dc   <= addr[`MMIO_TFT_DC_BIT];
                        tft_mosi <= data[31];        // first bit set up before any edge
                        bit_cnt  <= 5'd31;
                    end
                end
                mmio_pkg::tft_shift: begin
                    tft_sclk <= ~tft_sclk;
                    if (!tft_sclk) begin             // rising edge, receiver samples
                        if (bit_cnt == 5'd0) begin
                            state <= mmio_pkg::tft_done;  // last bit clocked
                        end
                    end else begin                   // falling edge, next bit out
                        tft_mosi <= shift_q[31];
                        bit_cnt  <= bit_cnt - 5'd1;
                    end
                end
                mmio_pkg::tft_done: begin
                    tft_sclk <= 1'b0;                // park the pins
                    tft_mosi <= 1'b0;
                    tft_cs_n <= 1'b1;
                    if (!wi) begin
                        state <= mmio_pkg::tft_idle;  // only after the cpu lets go
                    end
                end
                default: state <= mmio_pkg::tft_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == mmio_pkg::tft_idle) && wi) begin
            shift_q <= {data[30:0], 1'b0};           // bit 31 already on mosi
        end else if ((state == mmio_pkg::tft_shift) && tft_sclk) begin
            shift_q <= {shift_q[30:0], 1'b0};
        end
    end

endmodule

// File: source/data_memory.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module data_memory (
    input  logic            clk,
    input  logic            rst_n,
    input  mmio_pkg::rwi_t  rwi,         // 00/10 read, 01 write, 11 idle
    input  mmio_pkg::word_t addr,        // byte address
    input  mmio_pkg::word_t write_data,  // store data
    output mmio_pkg::word_t read_data,   // valid when busy drops
    output logic            busy         // high while the access is pending
);

    localparam logic [1:0] LATENCY = 2'(`MMIO_MEM_LATENCY);

    mmio_pkg::word_t      mem [`MMIO_MEM_WORDS];  // shared data and instruction store
    mmio_pkg::word_t      read_q;
    mmio_pkg::mem_index_t idx;                     // fetch at 8192+k lands on word k/4
    logic                 active;                  // any non-idle code
    logic                 last;                    // final busy cycle
    logic [1:0]           cnt;

    assign idx       = addr[12:2];
    assign active    = rwi != `MMIO_RWI_IDLE;
    assign busy      = active && (cnt < LATENCY);
    assign last      = active && (cnt == LATENCY - 2'd1);
    assign read_data = read_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!active) begin
            cnt <= '0;                                // ready for the next request
        end else if (busy) begin
            cnt <= cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (last) begin
            if (rwi == `MMIO_RWI_WRITE) begin
                mem[idx] <= write_data;
            end else begin
                read_q <= mem[idx];                   // data or instruction read
            end
        end
    end

endmodule

// File: source/mmio_subsystem_top.sv
`timescale 1ns/1ps

module mmio_subsystem_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mmio_pkg::word_t      mem_data_in,            // cpu store data
    input  mmio_pkg::rwi_t       rwi_in,                 // cpu request code
    input  mmio_pkg::word_t      addr_in,                // cpu byte address
    input  logic                 reg_load,               // sensor strobe
    input  mmio_pkg::reg_index_t reg_load_addr,
    input  mmio_pkg::word_t      reg_load_data,
    output logic                 busy,                   // back to the cpu
    output mmio_pkg::word_t      ext_data_out,           // load data
    output mmio_pkg::word_t      write_instruction_out,  // fetched instruction
    output logic                 tft_sclk,
    output logic                 tft_mosi,
    output logic                 tft_cs_n,
    output logic                 tft_dc
);

    logic            ri_out;              // decoder to register bank
    mmio_pkg::word_t addr_out_reg;
    mmio_pkg::word_t reg_data;
    logic            reg_busy;
    logic            wi_out;              // decoder to tft writer
    mmio_pkg::word_t addr_out_tft;
    mmio_pkg::word_t write_data_out_tft;
    logic            tft_busy;
    mmio_pkg::rwi_t  rwi_out;             // decoder to memory
    mmio_pkg::word_t addr_out;
    mmio_pkg::word_t write_data_out;
    mmio_pkg::word_t mem_read_data;
    logic            mem_busy;

    mmio_decoder u_decoder (
        .mem_data_in(mem_data_in), .rwi_in(rwi_in), .addr_in(addr_in),
        .ext_data_in(mem_read_data), .mem_busy(mem_busy),
        .reg_data_in(reg_data), .reg_busy(reg_busy), .tft_busy(tft_busy),
        .ri_out(ri_out), .addr_out_reg(addr_out_reg), .ext_data_out(ext_data_out),
        .busy(busy), .write_instruction_out(write_instruction_out),
        .write_data_out_tft(write_data_out_tft), .addr_out_tft(addr_out_tft),
        .wi_out(wi_out), .rwi_out(rwi_out), .addr_out(addr_out),
        .write_data_out(write_data_out)
    );

    ext_register_bank u_reg_bank (
        .clk(clk), .rst_n(rst_n), .ri(ri_out), .addr(addr_out_reg),
        .load(reg_load), .load_addr(reg_load_addr), .load_data(reg_load_data),
        .data(reg_data), .busy(reg_busy)
    );

    tft_spi_writer u_tft (
        .clk(clk), .rst_n(rst_n), .wi(wi_out), .addr(addr_out_tft),
        .data(write_data_out_tft), .busy(tft_busy), .tft_sclk(tft_sclk),
        .tft_mosi(tft_mosi), .tft_cs_n(tft_cs_n), .tft_dc(tft_dc)
    );

    data_memory u_mem (
        .clk(clk), .rst_n(rst_n), .rwi(rwi_out), .addr(addr_out),
        .write_data(write_data_out), .read_data(mem_read_data), .busy(mem_busy)
    );

endmodule

// File: bench/mmio_assertions.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 ri_out,     // decoder to register bank
    input logic                 wi_out,     // decoder to tft writer
    input mmio_pkg::rwi_t       rwi_out,    // decoder to memory
    input logic                 busy,       // busy back to the cpu
    input mmio_pkg::tft_state_t tft_state,  // tft writer fsm
    input logic                 tft_cs_n
);

    logic mem_req;  // memory sees a live code
    assign mem_req = rwi_out != `MMIO_RWI_IDLE;

    one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ri_out, wi_out, mem_req}))
        else $error("decoder selected more than one target");

    cs_in_shift: assert property (@(posedge clk) disable iff (!rst_n)
        (tft_state == mmio_pkg::tft_shift) |-> !tft_cs_n)
        else $error("tft chip select released during a frame");

    reg_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ri_out) |-> ##`MMIO_REG_LATENCY !busy)
        else $error("register read busy too long");

    mem_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> ##`MMIO_MEM_LATENCY !busy)
        else $error("memory access busy too long");

    tft_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wi_out) |-> ##64 !busy)  // 32 bits at two clocks each
        else $error("tft write busy too long");

endmodule

// top scope sees both the decoder wires and the tft writer state
bind mmio_subsystem_top mmio_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .ri_out(ri_out), .wi_out(wi_out), .rwi_out(rwi_out),
    .busy(busy), .tft_state(u_tft.state), .tft_cs_n(tft_cs_n)
);

// File: bench/mmio_tb.sv
`timescale 1ns/1ps
`include "mmio_defines.svh"

module mmio_tb;

    localparam int CLK_PERIOD   = 4;           // ns
    localparam int RESET_CYCLES = 4;
    localparam int MAX_REQUESTS = 40;          // upper bound on requests issued below
    localparam int REQ_CYCLES   = 100;         // generous, the longest request takes 65
    localparam int TFT_CYCLES   = 2 * 32 + 1;  // two clocks per bit plus the done cycle

    logic                 clk;
    logic                 rst_n;
    mmio_pkg::word_t      mem_data_in;
    mmio_pkg::rwi_t       rwi_in;
    mmio_pkg::word_t      addr_in;
    logic                 reg_load;
    mmio_pkg::reg_index_t reg_load_addr;
    mmio_pkg::word_t      reg_load_data;
    logic                 busy;
    mmio_pkg::word_t      ext_data_out;
    mmio_pkg::word_t      write_instruction_out;
    logic                 tft_sclk;
    logic                 tft_mosi;
    logic                 tft_cs_n;
    logic                 tft_dc;

    mmio_pkg::word_t reg_model [16];               // expected sensor registers
    mmio_pkg::word_t mem_model [`MMIO_MEM_WORDS];  // expected memory contents
    mmio_pkg::word_t mem_addrs [$];                // data addresses written so far
    mmio_pkg::word_t exp_q [$];                    // pending checks, expected side
    mmio_pkg::word_t got_q [$];                    // pending checks, observed side
    string           what_q [$];
    int              checks = 0;
    int              errors = 0;
    integer          seed;
    mmio_pkg::word_t spi_bits;                     // last 32 bits seen on mosi
    int              spi_edges;                    // rising sclk edges so far
    logic            spi_dc;                       // dc at the latest rising sclk
    logic            sclk_prev;

    mmio_subsystem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RESET_CYCLES * CLK_PERIOD + MAX_REQUESTS * REQ_CYCLES * CLK_PERIOD);
        $display("timeout: a request never completed, busy stayed high");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // expected data for a request and its completion cycle count
    function automatic mmio_pkg::word_t ref_result(input mmio_pkg::rwi_t code,
            input mmio_pkg::word_t addr, input mmio_pkg::word_t wdata, output int cycles);
        cycles     = 1;   // ignored, busy never rises
        ref_result = '0;
        if (addr >= `MMIO_DATA_LIMIT) begin
            if (code != `MMIO_RWI_IDLE) begin
                cycles     = `MMIO_MEM_LATENCY + 1;
                ref_result = mem_model[addr[12:2]];  // fetch folds onto the data words
            end
        end else if (code == `MMIO_RWI_WRITE) begin
            if (addr >= `MMIO_REG_LIMIT && addr < `MMIO_TFT_LIMIT) begin
                cycles     = TFT_CYCLES;
                ref_result = wdata;                  // frame seen on mosi
            end else if (addr >= `MMIO_TFT_LIMIT) begin
                cycles = `MMIO_MEM_LATENCY + 1;
            end
        end else if (code == `MMIO_RWI_READ) begin
            if (addr < `MMIO_REG_LIMIT) begin
                cycles     = `MMIO_REG_LATENCY + 1;
                ref_result = reg_model[addr[5:2]];   // upper bits alias
            end else if (addr >= `MMIO_TFT_LIMIT) begin
                cycles     = `MMIO_MEM_LATENCY + 1;
                ref_result = mem_model[addr[12:2]];
            end
        end
    endfunction

    task automatic queue_check(input string what, input mmio_pkg::word_t exp,
            input mmio_pkg::word_t got);
        exp_q.push_back(exp);
        got_q.push_back(got);
        what_q.push_back(what);
    endtask

    task automatic load_register(input mmio_pkg::reg_index_t idx, input mmio_pkg::word_t data);
        @(posedge clk);
        #1;
        reg_load      = 1'b1;  // single-cycle strobe
        reg_load_addr = idx;
        reg_load_data = data;
        @(posedge clk);
        #1;
        reg_load      = 1'b0;
        reg_model[idx] = data;
    endtask

    // hold the request until busy is low at a falling edge, then idle one cycle
    task automatic run_request(input mmio_pkg::rwi_t code, input mmio_pkg::word_t addr,
            input mmio_pkg::word_t wdata, output int cycles, output mmio_pkg::word_t ext,
            output mmio_pkg::word_t instr, output logic [2:0] pins);
        @(posedge clk);
        #1;
        rwi_in      = code;
        addr_in     = addr;
        mem_data_in = wdata;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy);
        ext   = ext_data_out;
        instr = write_instruction_out;
        pins  = {tft_cs_n, tft_sclk, tft_mosi};
        @(posedge clk);
        #1;
        rwi_in      = `MMIO_RWI_IDLE;
        addr_in     = '0;
        mem_data_in = '0;
    endtask

    task automatic do_request(input string what, input mmio_pkg::rwi_t code,
            input mmio_pkg::word_t addr, input mmio_pkg::word_t wdata);
        mmio_pkg::word_t exp_v;
        mmio_pkg::word_t ext;
        mmio_pkg::word_t instr;
        logic [2:0]      pins;
        int              exp_cycles;
        int              cycles;
        int              edges0;
        exp_v  = ref_result(code, addr, wdata, exp_cycles);
        edges0 = spi_edges;
        run_request(code, addr, wdata, cycles, ext, instr, pins);
        queue_check($sformatf("%s cycles", what), exp_cycles, cycles);
        if (exp_cycles == TFT_CYCLES) begin
            @(negedge clk);                          // last rising sclk already captured
            queue_check($sformatf("%s bit count", what), 32, spi_edges - edges0);
            queue_check($sformatf("%s frame", what), exp_v, spi_bits);
            queue_check($sformatf("%s dc", what), 32'(addr[`MMIO_TFT_DC_BIT]), 32'(spi_dc));
        end else if (addr >= `MMIO_DATA_LIMIT) begin
            queue_check($sformatf("%s instruction", what), exp_v, instr);
            queue_check($sformatf("%s ext data", what), '0, ext);
        end else begin
            queue_check($sformatf("%s ext data", what), exp_v, ext);
            queue_check($sformatf("%s instruction", what), '0, instr);
        end
        if (exp_cycles == 1) begin
            queue_check($sformatf("%s spi pins", what), 32'h4, 32'(pins));  // cs_n high only
        end
        if (code == `MMIO_RWI_WRITE && addr >= `MMIO_TFT_LIMIT && addr < `MMIO_DATA_LIMIT) begin
            mem_model[addr[12:2]] = wdata;
        end
    endtask

    // spi receiver, takes mosi on each rising sclk
    initial begin
        sclk_prev = 1'b0;
        spi_edges = 0;
        spi_bits  = '0;
        spi_dc    = 1'b0;
        forever begin
            @(negedge clk);
            if (tft_sclk && !sclk_prev) begin
                spi_bits = {spi_bits[30:0], tft_mosi};  // msb arrives first
                spi_dc   = tft_dc;
                spi_edges++;
            end
            sclk_prev = tft_sclk;
        end
    end

    // compare process
    initial begin
        mmio_pkg::word_t exp_v;
        mmio_pkg::word_t got_v;
        string           what;
        forever begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                exp_v = exp_q.pop_front();
                got_v = got_q.pop_front();
                what  = what_q.pop_front();
                checks++;
                assert (got_v === exp_v) else begin
                    errors++;
                    $display("error at %0t ns: %s expected %h, got %h", $time, what, exp_v, got_v);
                end
            end
        end
    end

    initial begin
        mmio_pkg::word_t addr;
        int              idx;
        seed          = 19;
        rst_n         = 1'b0;
        rwi_in        = `MMIO_RWI_IDLE;
        addr_in       = '0;
        mem_data_in   = '0;
        reg_load      = 1'b0;
        reg_load_addr = '0;
        reg_load_data = '0;
        for (int i = 0; i < 16; i++) begin
            reg_model[i] = '0;                       // bank clears on reset
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        do_request("register read after reset", `MMIO_RWI_READ, 32'd12, '0);
        for (int i = 0; i < 16; i++) begin
            load_register(4'(i), $random(seed));
        end
        for (int i = 0; i < 6; i++) begin
            idx  = $random(seed) & 15;
            addr = (($random(seed) & 15) << 6) | (idx << 2);  // bits 9..6 only alias
            do_request("register read", `MMIO_RWI_READ, addr, '0);
        end

        for (int i = 0; i < 6; i++) begin
            addr = `MMIO_TFT_LIMIT + (($unsigned($random(seed)) % 1536) << 2);
            mem_addrs.push_back(addr);
            do_request("memory write", `MMIO_RWI_WRITE, addr, $random(seed));
        end
        do_request("memory rewrite", `MMIO_RWI_WRITE, mem_addrs[0], $random(seed));
        foreach (mem_addrs[i]) begin
            do_request("memory read", `MMIO_RWI_READ, mem_addrs[i], '0);
        end
        for (int i = 0; i < 3; i++) begin
            do_request("instruction fetch", `MMIO_RWI_IFETCH,
                `MMIO_DATA_LIMIT + mem_addrs[i], '0);
        end

        do_request("tft data write", `MMIO_RWI_WRITE, `MMIO_REG_LIMIT + 32'd4, $random(seed));
        do_request("tft command write", `MMIO_RWI_WRITE, 32'd1536, $random(seed));

        do_request("write to register region", `MMIO_RWI_WRITE, 32'd64, $random(seed));
        do_request("read from tft region", `MMIO_RWI_READ, 32'd1100, '0);
        do_request("code 00 below fetch", `MMIO_RWI_IFETCH, mem_addrs[1], '0);
        do_request("code 11 below fetch", `MMIO_RWI_IDLE, 32'd200, '0);
        do_request("register after ignored write", `MMIO_RWI_READ, 32'd64, '0);

        repeat (2) @(negedge clk);                   // let the compare process drain
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mmio.f
+incdir+source
source/mmio_pkg.sv
source/mmio_decoder.sv
source/ext_register_bank.sv
source/tft_spi_writer.sv
source/data_memory.sv
source/mmio_subsystem_top.sv
bench/mmio_assertions.sv
bench/mmio_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mmio.f --top-module mmio_tb -o sim_mmio

out=$(./obj_dir/sim_mmio || true)
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
